// ==== Makefile ====
# Verilator build for the SCC testbench

VERILATOR ?= verilator
TOP       ?= scc_tb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/1ns -j 0
SIM       := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(wildcard logic/*.sv) $(wildcard dv/*.sv) $(wildcard dv/*.svh)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# exit status of the simulator is the result
run: $(SIM)
	$(SIM)

clean:
	rm -rf $(OBJ_DIR)

// ==== all.f ====
+incdir+dv
logic/scc_pkg.sv
logic/scc_bus_decode.sv
logic/scc_channel.sv
logic/scc_uart.sv
logic/scc_read_mux.sv
logic/scc_top.sv
dv/scc_tb.sv

// ==== dv/scc_tb_checks.svh ====
`ifndef SCC_TB_CHECKS_SVH
`define SCC_TB_CHECKS_SVH

// read data against the value worked out for the step
task automatic check_byte(input string name, input byte_t exp, input byte_t act);
	if (act !== exp) begin
		$display("ERR %s: expected %h, actual %h", name, exp, act);
		stop_run();
	end
endtask

// single pins, irq_n txd and rts
task automatic verify_level(input string name, input logic exp, input logic act);
	if (act !== exp) begin
		$display("ERR %s: expected %b, actual %b", name, exp, act);
		stop_run();
	end
endtask

function automatic logic pin_value(input reg_idx_t sel);
	return (sel == PIN_RTS) ? o_rts : o_irq_n;  // rts is the rx available flag
endfunction

// polls on falling edges, gives up after a few frame times
task automatic wait_for_pin(input string name, input reg_idx_t sel, input logic level);
	int cycles;
	cycles = 0;
	while (pin_value(sel) !== level && cycles <= 3 * FRAME_CLKS) begin
		@(negedge clk);
		cycles++;
	end
	if (pin_value(sel) !== level) begin
		$display("%s: timed out waiting for the pin to reach %b", name, level);
		stop_run();
	end
endtask

// 8N1 frame on rxd, lsb first
task automatic send_serial(input byte_t value);
	logic [9:0] frame;
	int         i;
	frame = {1'b1, value, 1'b0};  // stop, data, start
	for (i = 0; i < 10; i++) begin
		@(negedge clk);
		i_rxd = frame[i];
		repeat (BIT_CLKS - 1) @(negedge clk);  // hold for one bit time
	end
endtask

`endif

// ==== dv/scc_tb.sv ====
`default_nettype none

module scc_tb;
	timeunit 1ns;
	timeprecision 1ns;

	import scc_pkg::*;

	localparam int CLK_PERIOD   = 100;
	localparam int RESET_CYCLES = 16;
	localparam int BIT_CLKS     = 249;  // bit time at time constant 0
	localparam int FRAME_CLKS   = 10 * BIT_CLKS;

	localparam logic [1:0] RS_B      = 2'b00;  // channel b control
	localparam logic [1:0] RS_A      = 2'b01;
	localparam logic [1:0] RS_DATA_A = 2'b11;

	localparam reg_idx_t PIN_IRQ = 4'd0;
	localparam reg_idx_t PIN_RTS = 4'd1;
	localparam byte_t    ALL     = 8'hff;  // read mask, whole byte

	typedef enum logic [3:0] {
		OP_CTRL_WR, OP_DATA_WR, OP_CTRL_RD, OP_DATA_RD, OP_WAIT_RX,
		OP_WAIT_IRQ, OP_SEND_RX, OP_SET_DCD, OP_PIN
	} op_e;

	typedef struct {
		string      name;
		op_e        op;
		logic [1:0] rs;
		reg_idx_t   idx;   // register index, or pin for OP_PIN
		byte_t      data;  // write data, read mask, serial byte or dcd level
		byte_t      exp;
	} step_t;

	logic       clk = 1'b0;
	logic       reset_hw;
	logic       i_cs;
	logic       i_we;
	logic [1:0] i_rs;
	byte_t      i_wdata;
	logic       i_rxd;
	logic       i_cts;
	logic       i_dcd_a;
	logic       i_dcd_b;
	byte_t      o_rdata;
	logic       o_irq_n;
	logic       o_txd;
	logic       o_rts;

	step_t  steps[$];
	int     num_steps = 0;
	integer seed = 6373;
	byte_t  loop_byte;  // sent through local loopback
	byte_t  rx_byte;    // sent on rxd

	scc_top dut_i (.*);

	always #(CLK_PERIOD / 2) clk = ~clk;

	task automatic stop_run();
		$display("=== FAIL ===");
		$fatal(1, "run stopped at the first error");
	endtask

	`include "scc_tb_checks.svh"

	// wr0 byte that points at idx, anything above 7 needs point high
	function automatic byte_t pointer_byte(input reg_idx_t idx);
		wr0_u w;
		w.ptr.rst = 2'b00;
		w.ptr.cmd = idx[3] ? CMD_POINT_HIGH : 3'b000;  // 12 is point high plus 4
		w.ptr.idx = idx[2:0];
		return w.code;
	endfunction

	function automatic byte_t command_byte(input logic [2:0] cmd);
		wr0_u w;
		w.code    = '0;
		w.ptr.cmd = cmd;
		return w.code;
	endfunction

	// cs high across one rising edge then low across the next, pointer moves in the gap
	task automatic bus_cycle(input logic we, input logic [1:0] rs, input byte_t wdata,
		output byte_t rdata);
		@(negedge clk);
		i_cs    = 1'b1;
		i_we    = we;
		i_rs    = rs;
		i_wdata = wdata;
		#1;
		rdata = o_rdata;  // no edge before the rising one
		@(negedge clk);
		i_cs = 1'b0;
		i_we = 1'b0;
	endtask

	task automatic access_reg(input logic [1:0] rs, input reg_idx_t idx, input logic we,
		input byte_t wdata, output byte_t rdata);
		byte_t discard;
		if (idx != REG_WR0)
			bus_cycle(1'b1, rs, pointer_byte(idx), discard);
		bus_cycle(we, rs, wdata, rdata);
	endtask

	task automatic add_step(input string name, input op_e op, input logic [1:0] rs,
		input reg_idx_t idx, input byte_t data, input byte_t exp);
		steps.push_back(step_t'{name, op, rs, idx, data, exp});
	endtask

	task automatic apply_step(input step_t s);
		byte_t rd;
		case (s.op)
			OP_CTRL_WR: access_reg(s.rs, s.idx, 1'b1, s.data, rd);
			OP_DATA_WR: bus_cycle(1'b1, s.rs, s.data, rd);
			OP_CTRL_RD: begin
				access_reg(s.rs, s.idx, 1'b0, 8'h00, rd);
				check_byte(s.name, s.exp, rd & s.data);
			end
			OP_DATA_RD: begin
				bus_cycle(1'b0, s.rs, 8'h00, rd);
				check_byte(s.name, s.exp, rd & s.data);
			end
			OP_WAIT_RX:  wait_for_pin(s.name, PIN_RTS, 1'b1);
			OP_WAIT_IRQ: wait_for_pin(s.name, PIN_IRQ, 1'b0);
			OP_SEND_RX:  send_serial(s.data);
			OP_SET_DCD: begin
				@(negedge clk);
				if (s.rs[0])
					i_dcd_a = s.data[0];
				else
					i_dcd_b = s.data[0];
			end
			OP_PIN: begin
				@(negedge clk);  // pins only move on rising edges
				verify_level(s.name, s.exp[0], pin_value(s.idx));
			end
		endcase
	endtask

	task automatic build_table();
		// after reset
		add_step("rr15_a_reset",    OP_CTRL_RD,  RS_A, REG_WR15, ALL, 8'hf8);
		add_step("rr15_b_reset",    OP_CTRL_RD,  RS_B, REG_WR15, ALL, 8'hf8);
		add_step("rr0_a_tx_empty",  OP_CTRL_RD,  RS_A, REG_WR0,  8'h04, 8'h04);
		add_step("irq_idle",        OP_PIN,      RS_A, PIN_IRQ,  8'h00, 8'h01);
		// pointer and registers
		add_step("wr12_a",          OP_CTRL_WR,  RS_A, REG_WR12, 8'h5a, 8'h00);
		add_step("rr0_after_wr12",  OP_CTRL_RD,  RS_A, REG_WR0,  8'h04, 8'h04);
		add_step("wr13_a",          OP_CTRL_WR,  RS_A, REG_WR13, 8'ha5, 8'h00);
		add_step("wr12_b",          OP_CTRL_WR,  RS_B, REG_WR12, 8'h3c, 8'h00);
		add_step("wr13_b",          OP_CTRL_WR,  RS_B, REG_WR13, 8'hc3, 8'h00);
		add_step("rr12_a",          OP_CTRL_RD,  RS_A, REG_WR12, ALL, 8'h5a);
		add_step("rr13_a",          OP_CTRL_RD,  RS_A, REG_WR13, ALL, 8'ha5);
		add_step("rr12_b",          OP_CTRL_RD,  RS_B, REG_WR12, ALL, 8'h3c);
		add_step("rr9_mirror_b",    OP_CTRL_RD,  RS_B, REG_WR9,  ALL, 8'hc3);
		add_step("wr2_vector",      OP_CTRL_WR,  RS_A, REG_WR2,  8'h50, 8'h00);
		add_step("rr2_b_none",      OP_CTRL_RD,  RS_B, REG_WR2,  ALL, 8'h56);  // status 011
		// local loopback at time constant 0
		add_step("tc_low_a",        OP_CTRL_WR,  RS_A, REG_WR12, 8'h00, 8'h00);
		add_step("tc_high_a",       OP_CTRL_WR,  RS_A, REG_WR13, 8'h00, 8'h00);
		add_step("loop_on",         OP_CTRL_WR,  RS_A, REG_WR14, 8'h02, 8'h00);
		add_step("tx_byte",         OP_DATA_WR,  RS_DATA_A, REG_WR0, loop_byte, 8'h00);
		add_step("rr0_tx_busy",     OP_CTRL_RD,  RS_A, REG_WR0,  8'h04, 8'h00);
		add_step("wait_loop_rx",    OP_WAIT_RX,  RS_A, PIN_RTS,  8'h00, 8'h00);
		add_step("rr0_rx_avail",    OP_CTRL_RD,  RS_A, REG_WR0,  8'h01, 8'h01);
		add_step("rts_loop",        OP_PIN,      RS_A, PIN_RTS,  8'h00, 8'h01);  // control reads keep it
		add_step("loop_data",       OP_DATA_RD,  RS_DATA_A, REG_WR0, ALL, loop_byte);
		add_step("rts_after_read",  OP_PIN,      RS_A, PIN_RTS,  8'h00, 8'h00);
		add_step("loop_off",        OP_CTRL_WR,  RS_A, REG_WR14, 8'h00, 8'h00);
		// serial receive, all characters mode
		add_step("wr3_rx_en",       OP_CTRL_WR,  RS_A, REG_WR3,  8'h01, 8'h00);
		add_step("wr1_all_chars",   OP_CTRL_WR,  RS_A, REG_WR1,  8'h10, 8'h00);
		add_step("wr9_mie",         OP_CTRL_WR,  RS_A, REG_WR9,  8'h08, 8'h00);
		add_step("rx_serial",       OP_SEND_RX,  RS_A, REG_WR0,  rx_byte, 8'h00);
		add_step("wait_rx_irq",     OP_WAIT_IRQ, RS_A, PIN_IRQ,  8'h00, 8'h00);
		add_step("rr3_rx_pend",     OP_CTRL_RD,  RS_A, REG_WR3,  ALL, 8'h20);
		add_step("rr2_b_rx",        OP_CTRL_RD,  RS_B, REG_WR2,  ALL, 8'h5c);  // status 110
		add_step("rx_data",         OP_DATA_RD,  RS_DATA_A, REG_WR0, ALL, rx_byte);
		add_step("irq_after_read",  OP_PIN,      RS_A, PIN_IRQ,  8'h00, 8'h01);
		// dcd on channel b
		add_step("wr15_b_dcd",      OP_CTRL_WR,  RS_B, REG_WR15, 8'h08, 8'h00);
		add_step("wr1_b_ext",       OP_CTRL_WR,  RS_B, REG_WR1,  8'h01, 8'h00);
		add_step("dcd_b_rise",      OP_SET_DCD,  RS_B, REG_WR0,  8'h01, 8'h00);
		add_step("wait_dcd_irq",    OP_WAIT_IRQ, RS_A, PIN_IRQ,  8'h00, 8'h00);
		add_step("rr3_ext_b",       OP_CTRL_RD,  RS_A, REG_WR3,  ALL, 8'h01);
		add_step("dcd_b_fall",      OP_SET_DCD,  RS_B, REG_WR0,  8'h00, 8'h00);
		add_step("rr0_b_latched",   OP_CTRL_RD,  RS_B, REG_WR0,  8'h08, 8'h08);
		add_step("dcd_b_back",      OP_SET_DCD,  RS_B, REG_WR0,  8'h01, 8'h00);
		add_step("reset_ext_b",     OP_CTRL_WR,  RS_B, REG_WR0,
			command_byte(CMD_RESET_EXT), 8'h00);
		add_step("irq_after_reset", OP_PIN,      RS_A, PIN_IRQ,  8'h00, 8'h01);
		// soft resets
		add_step("wr15_a",          OP_CTRL_WR,  RS_A, REG_WR15, 8'h0a, 8'h00);
		add_step("wr12_a_keep",     OP_CTRL_WR,  RS_A, REG_WR12, 8'h77, 8'h00);
		add_step("chan_a_reset",    OP_CTRL_WR,  RS_A, REG_WR9,  {RST_CHAN_A, 6'd0}, 8'h00);
		add_step("rr15_a_kept",     OP_CTRL_RD,  RS_A, REG_WR15, ALL, 8'h0a);
		add_step("rr12_a_kept",     OP_CTRL_RD,  RS_A, REG_WR12, ALL, 8'h77);
		add_step("full_reset",      OP_CTRL_WR,  RS_A, REG_WR9,  {RST_FULL, 6'd0}, 8'h00);
		add_step("rr15_a_full",     OP_CTRL_RD,  RS_A, REG_WR15, ALL, 8'hf8);
		add_step("rr15_b_full",     OP_CTRL_RD,  RS_B, REG_WR15, ALL, 8'hf8);
	endtask

	// nothing is transmitted on the line, loopback keeps txd high
	always @(negedge clk) begin
		if (!reset_hw)
			verify_level("txd_idle", 1'b1, o_txd);
	end

	initial begin
		wait (num_steps != 0);
		#(longint'(num_steps) * 12 * FRAME_CLKS * CLK_PERIOD + RESET_CYCLES * CLK_PERIOD);
		$display("watchdog: the test timed out before all steps ran");
		stop_run();
	end

	initial begin
		reset_hw = 1'b1;
		i_cs     = 1'b0;
		i_we     = 1'b0;
		i_rs     = 2'b00;
		i_wdata  = 8'h00;
		i_rxd    = 1'b1;  // line idle
		i_cts    = 1'b0;
		i_dcd_a  = 1'b0;
		i_dcd_b  = 1'b0;
		loop_byte = byte_t'($random(seed));
		rx_byte   = byte_t'($random(seed));
		build_table();
		num_steps = steps.size();
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		reset_hw = 1'b0;
		foreach (steps[i])
			apply_step(steps[i]);
		repeat (4) @(negedge clk);
		$display("=== PASS ===");
		$finish;
	end

endmodule

`default_nettype wire

// ==== logic/scc_bus_decode.sv ====
`default_nettype none

module scc_bus_decode (
	input  logic              clk,
	input  logic              reset_hw,
	input  logic              i_cs,
	input  logic              i_we,
	input  logic [1:0]        i_rs,            // [1] data, [0] channel a
	input  scc_pkg::byte_t    i_wdata,
	output scc_pkg::reg_idx_t o_rindex,        // live pointer
	output logic [1:0]        o_wr_strobe,     // control write per channel
	output logic [1:0]        o_ext_reset,
	output logic              o_reset_full,
	output logic [1:0]        o_reset_chan,    // includes the full reset
	output logic              o_tx_write,
	output logic              o_rx_read,
	output logic              o_rx_first_set,
	output scc_pkg::byte_t    o_wr2,
	output logic [5:0]        o_wr9
);
	import scc_pkg::*;

	wr0_u     wr0;           // write data decoded as a wr0 byte
	reg_idx_t rindex_latch;  // pointer for the next access
	logic     ctl_access;
	logic     ctl_write;
	logic     wr0_write;
	logic     wr9_write;

	assign wr0.code   = i_wdata;
	assign ctl_access = i_cs & ~i_rs[1];
	assign ctl_write  = ctl_access & i_we;
	assign wr0_write  = ctl_write & (o_rindex == REG_WR0);
	assign wr9_write  = ctl_write & (o_rindex == REG_WR9);  // wr9 is shared by both channels

	assign o_wr_strobe[CHAN_A] = ctl_write & i_rs[0];
	assign o_wr_strobe[CHAN_B] = ctl_write & ~i_rs[0];
	assign o_ext_reset = o_wr_strobe & {2{wr0_write & (wr0.ptr.cmd == CMD_RESET_EXT)}};

	// wr9 soft resets as single clk pulses
	assign o_reset_full         = wr9_write & (wr0.ptr.rst == RST_FULL);
	assign o_reset_chan[CHAN_A] = o_reset_full | (wr9_write & (wr0.ptr.rst == RST_CHAN_A));
	assign o_reset_chan[CHAN_B] = o_reset_full | (wr9_write & (wr0.ptr.rst == RST_CHAN_B));

	assign o_tx_write     = i_cs & i_we & (i_rs == 2'b11);   // channel a data
	assign o_rx_read      = i_cs & ~i_we & (i_rs == 2'b11);
	assign o_rx_first_set = wr0_write & (wr0.ptr.cmd == CMD_RX_FIRST);  // either side

	// pointer latch, cleared by any control access except a wr0 write
	always_ff @(posedge clk or posedge reset_hw) begin
		if (reset_hw) begin
			rindex_latch <= '0;
		end else if (ctl_access) begin
			if (wr0_write)
				rindex_latch <= {wr0.ptr.cmd == CMD_POINT_HIGH, wr0.ptr.idx};
			else
				rindex_latch <= '0;
		end
	end

	// live pointer moves only between accesses so read data holds still
	always_ff @(posedge clk or posedge reset_hw) begin
		if (reset_hw)
			o_rindex <= '0;
		else if (!i_cs)
			o_rindex <= rindex_latch;
	end

	// shared registers, untouched by soft resets
	always_ff @(posedge clk or posedge reset_hw) begin
		if (reset_hw) begin
			o_wr2 <= '0;
			o_wr9 <= '0;
		end else if (ctl_write) begin
			if (o_rindex == REG_WR2)
				o_wr2 <= i_wdata;
			if (wr9_write)
				o_wr9 <= i_wdata[5:0];  // top bits are the reset command
		end
	end

endmodule

`default_nettype wire

// ==== logic/scc_channel.sv ====
`default_nettype none

module scc_channel (
	input  logic              clk,
	input  logic              reset_hw,
	input  logic              i_wr_strobe,   // control write to this channel
	input  scc_pkg::reg_idx_t i_rindex,
	input  scc_pkg::byte_t    i_wdata,
	input  logic              i_ext_reset,   // wr0 reset ext/status
	input  logic              i_reset_full,
	input  logic              i_reset_chan,
	input  logic              i_dcd,
	input  logic              i_cts,
	output scc_pkg::byte_t    o_wr1,
	output scc_pkg::byte_t    o_wr3,
	output scc_pkg::byte_t    o_wr12,
	output scc_pkg::byte_t    o_wr13,
	output scc_pkg::byte_t    o_wr14,
	output scc_pkg::byte_t    o_wr15,
	output logic              o_dcd_stat,
	output logic              o_cts_stat,
	output logic              o_ext_pend
);
	import scc_pkg::*;

	logic latch_open;  // status latch follows the pins while open
	logic dcd_latch;
	logic cts_latch;
	logic dcd_ip;
	logic cts_ip;
	logic do_latch;

	// registers that keep their value over soft resets
	always_ff @(posedge clk or posedge reset_hw) begin
		if (reset_hw) begin
			o_wr3  <= '0;
			o_wr12 <= '0;
			o_wr13 <= '0;
		end else if (i_wr_strobe) begin
			case (i_rindex)
				REG_WR3:  o_wr3  <= i_wdata;
				REG_WR12: o_wr12 <= i_wdata;  // time constant low
				REG_WR13: o_wr13 <= i_wdata;  // time constant high
				default:  ;
			endcase
		end
	end

	always_ff @(posedge clk or posedge reset_hw) begin
		if (reset_hw)
			o_wr1 <= '0;
		else if (i_reset_chan)
			o_wr1 <= {2'b00, o_wr1[5], 2'b00, o_wr1[2], 2'b00};  // bits 5 and 2 survive
		else if (i_wr_strobe && i_rindex == REG_WR1)
			o_wr1 <= i_wdata;
	end

	always_ff @(posedge clk or posedge reset_hw) begin
		if (reset_hw)
			o_wr14 <= '0;
		else if (i_reset_full)
			o_wr14 <= {o_wr14[7:6], WR14_FULL_RESET_LOW[5:0]};
		else if (i_reset_chan)
			o_wr14 <= {o_wr14[7:6], 4'b1000, o_wr14[1:0]};  // loop bits kept too
		else if (i_wr_strobe && i_rindex == REG_WR14)
			o_wr14 <= i_wdata;
	end

	always_ff @(posedge clk or posedge reset_hw) begin
		if (reset_hw)
			o_wr15 <= WR15_RESET;
		else if (i_reset_full)
			o_wr15 <= WR15_RESET;
		else if (i_wr_strobe && i_rindex == REG_WR15)
			o_wr15 <= i_wdata;
	end

	// a pin that differs from its latch and is enabled in wr15 closes the latch
	assign dcd_ip   = (i_dcd != dcd_latch) & o_wr15[3];
	assign cts_ip   = (i_cts != cts_latch) & o_wr15[5];
	assign do_latch = latch_open & (dcd_ip | cts_ip);

	always_ff @(posedge clk or posedge reset_hw) begin
		if (reset_hw) begin
			latch_open <= 1'b1;
			dcd_latch  <= 1'b0;
			cts_latch  <= 1'b0;
			o_ext_pend <= 1'b0;
		end else if (i_reset_full) begin
			latch_open <= 1'b1;
			dcd_latch  <= 1'b0;
			cts_latch  <= 1'b0;
			o_ext_pend <= 1'b0;
		end else if (i_ext_reset) begin
			latch_open <= 1'b1;  // reopen, pins are compared again
			o_ext_pend <= 1'b0;
		end else if (do_latch) begin
			latch_open <= 1'b0;
			dcd_latch  <= i_dcd;
			cts_latch  <= i_cts;
			o_ext_pend <= o_wr1[0];  // ext int enable
		end
	end

	// rr0 shows the latched level when the source is enabled
	assign o_dcd_stat = o_wr15[3] ? dcd_latch : i_dcd;
	assign o_cts_stat = o_wr15[5] ? cts_latch : i_cts;

endmodule

`default_nettype wire

// ==== logic/scc_pkg.sv ====
`default_nettype none

package scc_pkg;

	typedef logic [7:0]  byte_t;        // register and bus word
	typedef logic [3:0]  reg_idx_t;     // register pointer
	typedef logic [15:0] time_const_t;  // wr13 over wr12
	typedef logic [23:0] baud_div_t;    // clocks per bit

	// a wr0 byte is read as pointer plus command fields, or as one code
	typedef union packed {
		struct packed {
			logic [1:0] rst;  // reset field, same place as the wr9 soft reset bits
			logic [2:0] cmd;  // wr0 command
			logic [2:0] idx;  // low pointer bits
		} ptr;
		byte_t code;
	} wr0_u;

	// register indices, wr0 and rr0 share index 0
	localparam reg_idx_t REG_WR0  = 4'd0;
	localparam reg_idx_t REG_WR1  = 4'd1;
	localparam reg_idx_t REG_WR2  = 4'd2;
	localparam reg_idx_t REG_WR3  = 4'd3;
	localparam reg_idx_t REG_WR9  = 4'd9;
	localparam reg_idx_t REG_WR12 = 4'd12;
	localparam reg_idx_t REG_WR13 = 4'd13;
	localparam reg_idx_t REG_WR14 = 4'd14;
	localparam reg_idx_t REG_WR15 = 4'd15;

	localparam logic [2:0] CMD_POINT_HIGH = 3'b001;
	localparam logic [2:0] CMD_RESET_EXT  = 3'b010;  // reset ext/status interrupts
	localparam logic [2:0] CMD_RX_FIRST   = 3'b100;  // enable int on next rx char

	localparam logic [1:0] RST_FULL   = 2'b11;
	localparam logic [1:0] RST_CHAN_A = 2'b10;
	localparam logic [1:0] RST_CHAN_B = 2'b01;

	localparam byte_t WR15_RESET          = 8'hf8;
	localparam byte_t WR14_FULL_RESET_LOW = 8'b0011_0000;  // only bits 5..0 apply
	localparam byte_t RR15_READ_MASK      = 8'hfa;

	// time constant to divider, scc clock 14.32 MHz
	localparam time_const_t BAUD_TC_300   = 16'd380;
	localparam time_const_t BAUD_TC_1200  = 16'd94;
	localparam time_const_t BAUD_TC_2400  = 16'd46;
	localparam time_const_t BAUD_TC_4800  = 16'd22;
	localparam time_const_t BAUD_TC_9600  = 16'd10;
	localparam time_const_t BAUD_TC_14400 = 16'd6;
	localparam time_const_t BAUD_TC_19200 = 16'd4;
	localparam time_const_t BAUD_TC_28800 = 16'd2;
	localparam time_const_t BAUD_TC_38400 = 16'd1;
	localparam time_const_t BAUD_TC_57600 = 16'd0;

	localparam baud_div_t BAUD_DIV_300     = 24'd47733;
	localparam baud_div_t BAUD_DIV_1200    = 24'd11933;
	localparam baud_div_t BAUD_DIV_2400    = 24'd5967;
	localparam baud_div_t BAUD_DIV_4800    = 24'd2983;
	localparam baud_div_t BAUD_DIV_9600    = 24'd1492;
	localparam baud_div_t BAUD_DIV_14400   = 24'd994;
	localparam baud_div_t BAUD_DIV_19200   = 24'd746;
	localparam baud_div_t BAUD_DIV_28800   = 24'd497;
	localparam baud_div_t BAUD_DIV_38400   = 24'd373;
	localparam baud_div_t BAUD_DIV_57600   = 24'd249;
	localparam baud_div_t BAUD_DIV_DEFAULT = BAUD_DIV_9600;  // unknown constants run 9600

	// channel numbering follows rs[0]
	localparam int NUM_CHAN = 2;
	localparam int CHAN_A   = 1;
	localparam int CHAN_B   = 0;

endpackage

`default_nettype wire

// ==== logic/scc_read_mux.sv ====
`default_nettype none

module scc_read_mux (
	input  logic                                  [1:0] i_rs,
	input  scc_pkg::reg_idx_t                           i_rindex,
	input  scc_pkg::byte_t [scc_pkg::NUM_CHAN-1:0]      i_wr1,
	input  scc_pkg::byte_t [scc_pkg::NUM_CHAN-1:0]      i_wr3,
	input  scc_pkg::byte_t [scc_pkg::NUM_CHAN-1:0]      i_wr12,
	input  scc_pkg::byte_t [scc_pkg::NUM_CHAN-1:0]      i_wr13,
	input  scc_pkg::byte_t [scc_pkg::NUM_CHAN-1:0]      i_wr15,
	input  logic           [scc_pkg::NUM_CHAN-1:0]      i_dcd_stat,
	input  logic           [scc_pkg::NUM_CHAN-1:0]      i_cts_stat,
	input  logic           [scc_pkg::NUM_CHAN-1:0]      i_ext_pend,
	input  scc_pkg::byte_t                              i_wr2,
	input  logic           [5:0]                        i_wr9,
	input  logic                                        i_tx_busy,
	input  scc_pkg::byte_t                              i_rx_data,
	input  logic                                        i_rx_avail,
	input  logic                                        i_rx_first,
	output scc_pkg::byte_t                              o_rdata,
	output logic                                        o_irq_n
);
	import scc_pkg::*;

	byte_t [NUM_CHAN-1:0] rr0;
	byte_t [NUM_CHAN-1:0] rr1;
	byte_t [NUM_CHAN-1:0] rr2;
	byte_t [NUM_CHAN-1:0] rr3;
	byte_t [NUM_CHAN-1:0] rr15;
	byte_t                data;
	logic  [1:0]          rx_mode;   // wr1 bits 4:3 of channel a
	logic                 rx_pend_a;
	logic  [2:0]          vec_stat;

	// rr0 is break, eom, cts, hunt, dcd, tx empty, zero count, rx avail
	assign rr0[CHAN_A] = {2'b00, i_cts_stat[CHAN_A], 1'b0, i_dcd_stat[CHAN_A],
		~i_tx_busy, 1'b0, i_rx_avail};
	assign rr0[CHAN_B] = {2'b00, i_cts_stat[CHAN_B], 1'b0, i_dcd_stat[CHAN_B], 3'b100};

	assign rr1[CHAN_A] = {5'b00000, 2'b11, ~i_tx_busy};  // residue 011, all sent
	assign rr1[CHAN_B] = {5'b00000, 2'b11, 1'b1};

	// channel b rr2 carries the status code low or high
	assign rr2[CHAN_A] = i_wr2;
	assign rr2[CHAN_B] = i_wr9[4] ? {i_wr2[7], vec_stat[0], vec_stat[1], vec_stat[2], i_wr2[3:0]}
		: {i_wr2[7:4], vec_stat, i_wr2[0]};

	assign rr3[CHAN_A] = {2'b00, rx_pend_a, 1'b0, i_ext_pend[CHAN_A], 2'b00, i_ext_pend[CHAN_B]};
	assign rr3[CHAN_B] = '0;  // pending bits read on channel a only

	assign rr15[CHAN_A] = i_wr15[CHAN_A] & RR15_READ_MASK;
	assign rr15[CHAN_B] = i_wr15[CHAN_B] & RR15_READ_MASK;

	assign data = i_rs[0] ? i_rx_data : '0;  // no channel b data register

	always_comb begin
		if (i_rs[1]) begin
			o_rdata = data;
		end else begin
			case (i_rindex)
				REG_WR0, 4'd4:     o_rdata = rr0[i_rs[0]];
				REG_WR1, 4'd5:     o_rdata = rr1[i_rs[0]];
				REG_WR2, 4'd6:     o_rdata = rr2[i_rs[0]];
				REG_WR3, 4'd7:     o_rdata = rr3[i_rs[0]];
				4'd8:              o_rdata = data;
				REG_WR9, REG_WR13: o_rdata = i_wr13[i_rs[0]];  // 9 mirrors 13
				REG_WR12:          o_rdata = i_wr12[i_rs[0]];
				4'd11, REG_WR15:   o_rdata = rr15[i_rs[0]];
				default:           o_rdata = '0;  // rr10 and its mirror
			endcase
		end
	end

	// mode 01 waits for the first char, 10 takes every char
	assign rx_mode   = i_wr1[CHAN_A][4:3];
	assign rx_pend_a = i_wr3[CHAN_A][0] & i_rx_avail
		& ((rx_mode == 2'b01 && i_rx_first) || rx_mode == 2'b10);

	always_comb begin
		if (rx_pend_a)
			vec_stat = 3'b110;
		else if (i_ext_pend[CHAN_A])
			vec_stat = 3'b101;
		else if (i_ext_pend[CHAN_B])
			vec_stat = 3'b001;
		else
			vec_stat = 3'b011;  // nothing pending
	end

	assign o_irq_n = ~(i_wr9[3] & (rx_pend_a | (|i_ext_pend)));  // master enable

endmodule

`default_nettype wire

// ==== logic/scc_top.sv ====
`default_nettype none

module scc_top (
	input  logic           clk,
	input  logic           reset_hw,
	input  logic           i_cs,
	input  logic           i_we,
	input  logic [1:0]     i_rs,
	input  scc_pkg::byte_t i_wdata,
	input  logic           i_rxd,
	input  logic           i_cts,
	input  logic           i_dcd_a,
	input  logic           i_dcd_b,
	output scc_pkg::byte_t o_rdata,
	output logic           o_irq_n,
	output logic           o_txd,
	output logic           o_rts
);
	import scc_pkg::*;

	reg_idx_t             rindex;
	logic [NUM_CHAN-1:0]  wr_strobe;
	logic [NUM_CHAN-1:0]  ext_reset;
	logic [NUM_CHAN-1:0]  reset_chan;
	logic                 reset_full;
	logic                 tx_write;
	logic                 rx_read;
	logic                 rx_first_set;
	byte_t                wr2;
	logic [5:0]           wr9;
	byte_t [NUM_CHAN-1:0] wr1;
	byte_t [NUM_CHAN-1:0] wr3;
	byte_t [NUM_CHAN-1:0] wr12;
	byte_t [NUM_CHAN-1:0] wr13;
	byte_t [NUM_CHAN-1:0] wr14;
	byte_t [NUM_CHAN-1:0] wr15;
	logic [NUM_CHAN-1:0]  dcd_stat;
	logic [NUM_CHAN-1:0]  cts_stat;
	logic [NUM_CHAN-1:0]  ext_pend;
	logic [NUM_CHAN-1:0]  dcd_pin;
	logic [NUM_CHAN-1:0]  cts_pin;
	logic                 tx_busy;
	byte_t                rx_data;
	logic                 rx_avail;
	logic                 rx_first;

	assign dcd_pin = {i_dcd_a, i_dcd_b};  // bit CHAN_A is channel a
	assign cts_pin = {~tx_busy, i_cts};   // channel a cts tracks the transmitter
	assign o_rts   = rx_avail;

	scc_bus_decode bus_i (
		.clk, .reset_hw, .i_cs, .i_we, .i_rs, .i_wdata,
		.o_rindex       (rindex),
		.o_wr_strobe    (wr_strobe),
		.o_ext_reset    (ext_reset),
		.o_reset_full   (reset_full),
		.o_reset_chan   (reset_chan),
		.o_tx_write     (tx_write),
		.o_rx_read      (rx_read),
		.o_rx_first_set (rx_first_set),
		.o_wr2          (wr2),
		.o_wr9          (wr9)
	);

	for (genvar c = 0; c < NUM_CHAN; c++) begin : g_chan
		scc_channel chan_i (
			.clk, .reset_hw, .i_wdata,
			.i_wr_strobe  (wr_strobe[c]),
			.i_rindex     (rindex),
			.i_ext_reset  (ext_reset[c]),
			.i_reset_full (reset_full),
			.i_reset_chan (reset_chan[c]),
			.i_dcd        (dcd_pin[c]),
			.i_cts        (cts_pin[c]),
			.o_wr1        (wr1[c]),
			.o_wr3        (wr3[c]),
			.o_wr12       (wr12[c]),
			.o_wr13       (wr13[c]),
			.o_wr14       (wr14[c]),
			.o_wr15       (wr15[c]),
			.o_dcd_stat   (dcd_stat[c]),
			.o_cts_stat   (cts_stat[c]),
			.o_ext_pend   (ext_pend[c])
		);
	end

	scc_uart uart_a_i (
		.clk, .reset_hw, .i_wdata, .i_rxd,
		.i_reset_chan_a (reset_chan[CHAN_A]),
		.i_time_const   ({wr13[CHAN_A], wr12[CHAN_A]}),
		.i_wr14_loop    (wr14[CHAN_A][1:0]),
		.i_tx_write     (tx_write),
		.i_rx_read      (rx_read),
		.i_rx_first_set (rx_first_set),
		.o_txd          (o_txd),
		.o_tx_busy      (tx_busy),
		.o_rx_data      (rx_data),
		.o_rx_avail     (rx_avail),
		.o_rx_first     (rx_first)
	);

	scc_read_mux rmux_i (
		.i_rs, .o_rdata, .o_irq_n,
		.i_rindex   (rindex),
		.i_wr1      (wr1),
		.i_wr3      (wr3),
		.i_wr12     (wr12),
		.i_wr13     (wr13),
		.i_wr15     (wr15),
		.i_dcd_stat (dcd_stat),
		.i_cts_stat (cts_stat),
		.i_ext_pend (ext_pend),
		.i_wr2      (wr2),
		.i_wr9      (wr9),
		.i_tx_busy  (tx_busy),
		.i_rx_data  (rx_data),
		.i_rx_avail (rx_avail),
		.i_rx_first (rx_first)
	);

endmodule

`default_nettype wire

// ==== logic/scc_uart.sv ====
`default_nettype none

module scc_uart (
	input  logic                 clk,
	input  logic                 reset_hw,
	input  logic                 i_reset_chan_a,
	input  scc_pkg::time_const_t i_time_const,
	input  logic [1:0]           i_wr14_loop,
	input  logic                 i_tx_write,
	input  scc_pkg::byte_t       i_wdata,
	input  logic                 i_rx_read,
	input  logic                 i_rx_first_set,
	input  logic                 i_rxd,
	output logic                 o_txd,
	output logic                 o_tx_busy,
	output scc_pkg::byte_t       o_rx_data,    // holding register
	output logic                 o_rx_avail,
	output logic                 o_rx_first
);
	import scc_pkg::*;

	baud_div_t  baud_div;
	logic       loop_en;
	logic [9:0] tx_shift;  // stop, data lsb first, start
	baud_div_t  tx_cnt;
	logic [3:0] tx_bits;
	logic [1:0] rx_sync;
	logic       rx_in;
	logic       rx_active;
	baud_div_t  rx_cnt;    // counts down to the next sample point
	logic [3:0] rx_bits;   // 0 start, 1..8 data, 9 stop
	byte_t      rx_shift;

	always_ff @(posedge clk or posedge reset_hw) begin
		if (reset_hw) begin
			baud_div <= BAUD_DIV_DEFAULT;
		end else begin
			case (i_time_const)
				BAUD_TC_300:   baud_div <= BAUD_DIV_300;
				BAUD_TC_1200:  baud_div <= BAUD_DIV_1200;
				BAUD_TC_2400:  baud_div <= BAUD_DIV_2400;
				BAUD_TC_4800:  baud_div <= BAUD_DIV_4800;
				BAUD_TC_9600:  baud_div <= BAUD_DIV_9600;
				BAUD_TC_14400: baud_div <= BAUD_DIV_14400;
				BAUD_TC_19200: baud_div <= BAUD_DIV_19200;
				BAUD_TC_28800: baud_div <= BAUD_DIV_28800;
				BAUD_TC_38400: baud_div <= BAUD_DIV_38400;
				BAUD_TC_57600: baud_div <= BAUD_DIV_57600;
				default:       baud_div <= BAUD_DIV_DEFAULT;
			endcase
		end
	end

	assign loop_en = i_wr14_loop inside {2'b10, 2'b11};  // local loopback
	assign o_txd   = loop_en ? 1'b1 : tx_shift[0];        // line idles during loopback

	// transmitter, writes while busy are dropped
	always_ff @(posedge clk or posedge reset_hw) begin
		if (reset_hw) begin
			o_tx_busy <= 1'b0;
			tx_shift  <= '1;
			tx_cnt    <= '0;
			tx_bits   <= '0;
		end else if (i_reset_chan_a) begin
			o_tx_busy <= 1'b0;
			tx_shift  <= '1;
			tx_cnt    <= '0;
			tx_bits   <= '0;
		end else if (!o_tx_busy) begin
			if (i_tx_write) begin
				o_tx_busy <= 1'b1;
				tx_shift  <= {1'b1, i_wdata, 1'b0};
				tx_cnt    <= '0;
				tx_bits   <= '0;
			end
		end else if (tx_cnt == baud_div - 1'b1) begin
			tx_cnt   <= '0;
			tx_shift <= {1'b1, tx_shift[9:1]};  // shift in idle
			if (tx_bits == 4'd9)
				o_tx_busy <= 1'b0;  // stop bit done
			else
				tx_bits <= tx_bits + 1'b1;
		end else begin
			tx_cnt <= tx_cnt + 1'b1;
		end
	end

	// two flop sync, loopback taps the transmitter before the txd gate
	always_ff @(posedge clk or posedge reset_hw) begin
		if (reset_hw)
			rx_sync <= '1;
		else
			rx_sync <= {rx_sync[0], loop_en ? tx_shift[0] : i_rxd};
	end
	assign rx_in = rx_sync[1];

	always_ff @(posedge clk or posedge reset_hw) begin
		if (reset_hw) begin
			rx_active  <= 1'b0;
			rx_cnt     <= '0;
			rx_bits    <= '0;
			o_rx_avail <= 1'b0;
		end else if (i_reset_chan_a) begin
			rx_active  <= 1'b0;
			rx_cnt     <= '0;
			rx_bits    <= '0;
			o_rx_avail <= 1'b0;
		end else begin
			if (i_rx_read)
				o_rx_avail <= 1'b0;
			if (!rx_active) begin
				if (!rx_in) begin  // start edge
					rx_active <= 1'b1;
					rx_cnt    <= baud_div >> 1;  // aim at mid bit
					rx_bits   <= '0;
				end
			end else if (rx_cnt != '0) begin
				rx_cnt <= rx_cnt - 1'b1;
			end else begin
				rx_cnt  <= baud_div - 1'b1;
				rx_bits <= rx_bits + 1'b1;
				if (rx_bits == 4'd0 && rx_in) begin
					rx_active <= 1'b0;  // glitch, no start bit
				end else if (rx_bits == 4'd9) begin
					rx_active <= 1'b0;
					if (rx_in)
						o_rx_avail <= 1'b1;  // framing errors are dropped
				end
			end
		end
	end

	// payload, a new character overwrites the holding register
	always_ff @(posedge clk) begin
		if (rx_active && rx_cnt == '0) begin
			if (rx_bits inside {[4'd1:4'd8]})
				rx_shift <= {rx_in, rx_shift[7:1]};
			if (rx_bits == 4'd9 && rx_in)
				o_rx_data <= rx_shift;
		end
	end

	always_ff @(posedge clk or posedge reset_hw) begin
		if (reset_hw)
			o_rx_first <= 1'b1;
		else if (i_reset_chan_a || i_rx_first_set)
			o_rx_first <= 1'b1;
		else if (i_rx_read)
			o_rx_first <= 1'b0;  // first char taken
	end

endmodule

`default_nettype wire
